//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = i3c_hdr_tb
FILELIST = i3c_hdr.f
RUNFLAGS = +verilator+error+limit+100

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) $(RUNFLAGS) | tee /dev/stderr | grep -x "TEST PASS" > /dev/null

clean:
	rm -rf obj_dir

//--- i3c_hdr.f
source/i3c_hdr_pkg.sv
source/hdr_ccc_unit.sv
source/hdr_ddr_unit.sv
source/hdr_engine.sv
source/i3c_hdr_top.sv
testbench/i3c_hdr_assert.sv
testbench/i3c_hdr_tb.sv

//--- source/hdr_ccc_unit.sv
// hdr ccc transfer unit
`timescale 1ns/1ps

module hdr_ccc_unit #(
  parameter int CCC_BASE_ADDR = 0,
  parameter int DUMMY_ADDR    = 450,
  parameter int IDLE_ADDR     = 1000
) (
  input  logic                       i_sys_clk,
  input  logic                       i_sys_rst_n,
  input  logic                       i_en,
  input  logic                       i_dummy,
  input  logic [3:0]                 i_frame_cnt,
  output logic                       o_done,
  output i3c_hdr_pkg::hdr_bus_ctrl_t o_ctrl
);

  i3c_hdr_pkg::bit_cnt_t   bit_cnt;
  logic [3:0]              word_cnt;
  logic [3:0]              word_last;
  logic                    last_word;
  logic                    done_hold;  // set after done until enable drops
  i3c_hdr_pkg::regf_addr_t word_addr;

  assign word_last = i_dummy ? 4'd0 : i_frame_cnt - 4'd1;  // dummy is a single word
  assign last_word = (word_cnt == word_last);

  always_comb begin
    if (i_dummy) begin
      word_addr = i3c_hdr_pkg::regf_addr_t'(DUMMY_ADDR);
    end else begin
      word_addr = i3c_hdr_pkg::regf_addr_t'(CCC_BASE_ADDR)
                + i3c_hdr_pkg::regf_addr_t'(word_cnt);
    end
  end

  always_ff @(posedge i_sys_clk or negedge i_sys_rst_n) begin
    if (!i_sys_rst_n) begin
      bit_cnt   <= '0;
      word_cnt  <= '0;
      done_hold <= 1'b0;
      o_done    <= 1'b0;
      o_ctrl    <= i3c_hdr_pkg::idle_ctrl(IDLE_ADDR);
    end else begin
      o_done <= 1'b0;
      if (!i_en || done_hold) begin
        bit_cnt   <= '0;
        word_cnt  <= '0;
        done_hold <= done_hold && i_en;
        o_ctrl    <= i3c_hdr_pkg::idle_ctrl(IDLE_ADDR);
      end else begin
        o_ctrl.tx_en      <= 1'b1;
        o_ctrl.rx_en      <= 1'b0;
        o_ctrl.bit_cnt_en <= 1'b1;
        o_ctrl.regf_rd_en <= (bit_cnt == '0);  // fetch at word start
        o_ctrl.regf_addr  <= word_addr;
        // command word goes open drain
        o_ctrl.scl_pp_od  <= i_dummy || (word_cnt != 4'd0);
        if (bit_cnt == i3c_hdr_pkg::LAST_BIT) begin
          bit_cnt <= '0;
          if (last_word) begin
            word_cnt  <= '0;
            o_done    <= 1'b1;
            done_hold <= 1'b1;
          end else begin
            word_cnt <= word_cnt + 4'd1;
          end
        end else begin
          bit_cnt <= bit_cnt + 1'b1;
        end
      end
    end
  end

endmodule

//--- source/hdr_ddr_unit.sv
// hdr ddr data unit
`timescale 1ns/1ps

module hdr_ddr_unit #(
  parameter int DDR_BASE_ADDR = 512,
  parameter int IDLE_ADDR     = 1000
) (
  input  logic                       i_sys_clk,
  input  logic                       i_sys_rst_n,
  input  logic                       i_en,
  input  logic [3:0]                 i_frame_cnt,
  output logic                       o_done,
  output i3c_hdr_pkg::hdr_bus_ctrl_t o_ctrl
);

  i3c_hdr_pkg::bit_cnt_t   bit_cnt;
  logic [3:0]              word_cnt;
  logic                    last_word;
  logic                    done_hold;
  i3c_hdr_pkg::regf_addr_t word_addr;

  assign last_word = (word_cnt == i_frame_cnt - 4'd1);
  assign word_addr = i3c_hdr_pkg::regf_addr_t'(DDR_BASE_ADDR)
                   + i3c_hdr_pkg::regf_addr_t'(word_cnt);

  always_ff @(posedge i_sys_clk or negedge i_sys_rst_n) begin
    if (!i_sys_rst_n) begin
      bit_cnt   <= '0;
      word_cnt  <= '0;
      done_hold <= 1'b0;
      o_done    <= 1'b0;
      o_ctrl    <= i3c_hdr_pkg::idle_ctrl(IDLE_ADDR);
    end else begin
      o_done <= 1'b0;
      if (!i_en || done_hold) begin
        // parked until the engine drops enable
        bit_cnt   <= '0;
        word_cnt  <= '0;
        done_hold <= done_hold && i_en;
        o_ctrl    <= i3c_hdr_pkg::idle_ctrl(IDLE_ADDR);
      end else begin
        o_ctrl.tx_en      <= 1'b1;
        o_ctrl.rx_en      <= 1'b0;
        o_ctrl.bit_cnt_en <= 1'b1;
        o_ctrl.scl_pp_od  <= 1'b1;  // ddr is always push-pull
        o_ctrl.regf_rd_en <= (bit_cnt == '0);
        o_ctrl.regf_addr  <= word_addr;
        if (bit_cnt == i3c_hdr_pkg::LAST_BIT) begin
          bit_cnt <= '0;
          if (last_word) begin
            word_cnt  <= '0;
            o_done    <= 1'b1;  // with the last bit
            done_hold <= 1'b1;
          end else begin
            word_cnt <= word_cnt + 4'd1;
          end
        end else begin
          bit_cnt <= bit_cnt + 1'b1;
        end
      end
    end
  end

endmodule

//--- source/hdr_engine.sv
// hdr sequencer
`timescale 1ns/1ps

module hdr_engine #(
  parameter int IDLE_ADDR = 1000
) (
  input  logic                       i_sys_clk,
  input  logic                       i_sys_rst_n,
  input  logic                       i_hdr_en,
  input  logic                       i_cp,
  input  logic                       i_toc,
  input  logic [2:0]                 i_mode,
  input  logic                       i_ccc_done,
  input  logic                       i_ddr_done,
  input  i3c_hdr_pkg::hdr_bus_ctrl_t i_ccc_ctrl,
  input  i3c_hdr_pkg::hdr_bus_ctrl_t i_ddr_ctrl,
  output logic                       o_ccc_en,
  output logic                       o_ccc_dummy,
  output logic                       o_ddr_en,
  output logic                       o_hdr_done,
  output i3c_hdr_pkg::hdr_bus_ctrl_t o_bus_ctrl,
  output i3c_hdr_pkg::hdr_src_e      o_active_src
);

  i3c_hdr_pkg::hdr_state_e state;
  logic                    cp_q;
  logic                    toc_q;
  logic [2:0]              mode_q;
  logic                    exit_now;

  // exit unless toc asks for restart and we stay in ddr mode
  assign exit_now = toc_q || (mode_q != i3c_hdr_pkg::MODE_HDR_DDR);

  always_ff @(posedge i_sys_clk or negedge i_sys_rst_n) begin
    if (!i_sys_rst_n) begin
      state        <= i3c_hdr_pkg::IDLE;
      cp_q         <= 1'b0;
      toc_q        <= 1'b0;
      mode_q       <= i3c_hdr_pkg::MODE_HDR_DDR;
      o_ccc_en     <= 1'b0;
      o_ccc_dummy  <= 1'b0;
      o_ddr_en     <= 1'b0;
      o_hdr_done   <= 1'b0;
      o_active_src <= i3c_hdr_pkg::SRC_CCC;
    end else begin
      o_hdr_done <= 1'b0;
      if (state == i3c_hdr_pkg::IDLE) begin
        cp_q   <= i_cp;  // config tracks the regfile while idle
        toc_q  <= i_toc;
        mode_q <= i_mode;
        if (i_hdr_en) begin
          if (cp_q) begin
            state        <= i3c_hdr_pkg::CCC;
            o_ccc_en     <= 1'b1;
            o_active_src <= i3c_hdr_pkg::SRC_CCC;
          end else begin
            state        <= i3c_hdr_pkg::DDR_MODE;
            o_ddr_en     <= 1'b1;
            o_active_src <= i3c_hdr_pkg::SRC_DDR;
          end
        end
      end else if (!i_hdr_en) begin
        // abort, no done pulse
        state       <= i3c_hdr_pkg::IDLE;
        o_ccc_en    <= 1'b0;
        o_ddr_en    <= 1'b0;
        o_ccc_dummy <= 1'b0;
      end else begin
        cp_q <= i_cp;
        case (state)
          i3c_hdr_pkg::CCC: begin
            if (i_ccc_done) begin
              o_ccc_en <= 1'b0;
              if (o_ccc_dummy) begin
                // dummy word sent, ddr data follows
                o_ccc_dummy  <= 1'b0;
                state        <= i3c_hdr_pkg::DDR_MODE;
                o_active_src <= i3c_hdr_pkg::SRC_DDR;
              end else if (exit_now) begin
                state      <= i3c_hdr_pkg::IDLE;
                o_hdr_done <= 1'b1;
              end else begin
                toc_q       <= i_toc;
                mode_q      <= i_mode;
                o_ccc_dummy <= !cp_q;  // ccc then ddr needs one dummy word
              end
            end else if (!o_ccc_en) begin
              o_ccc_en <= 1'b1;  // rearm after the gap cycle
            end
          end
          i3c_hdr_pkg::DDR_MODE: begin
            if (i_ddr_done) begin
              o_ddr_en <= 1'b0;
              if (exit_now) begin
                state      <= i3c_hdr_pkg::IDLE;
                o_hdr_done <= 1'b1;
              end else begin
                toc_q  <= i_toc;
                mode_q <= i_mode;
                if (cp_q) begin
                  state        <= i3c_hdr_pkg::CCC;
                  o_active_src <= i3c_hdr_pkg::SRC_CCC;
                end
              end
            end else if (!o_ddr_en) begin
              o_ddr_en <= 1'b1;
            end
          end
          default: state <= i3c_hdr_pkg::IDLE;
        endcase
      end
    end
  end

  // one select for the whole bundle
  always_ff @(posedge i_sys_clk or negedge i_sys_rst_n) begin
    if (!i_sys_rst_n) begin
      o_bus_ctrl <= i3c_hdr_pkg::idle_ctrl(IDLE_ADDR);
    end else if (state == i3c_hdr_pkg::IDLE) begin
      o_bus_ctrl <= i3c_hdr_pkg::idle_ctrl(IDLE_ADDR);
    end else if (o_active_src == i3c_hdr_pkg::SRC_CCC) begin
      o_bus_ctrl <= i_ccc_ctrl;
    end else begin
      o_bus_ctrl <= i_ddr_ctrl;
    end
  end

endmodule

//--- source/i3c_hdr_pkg.sv
// i3c hdr shared definitions
package i3c_hdr_pkg;

  localparam int WORD_BITS   = 20;  // 2 preamble, 16 data, 2 parity
  localparam int REGF_ADDR_W = 12;
  localparam int BIT_CNT_W   = $clog2(WORD_BITS);

  typedef logic [REGF_ADDR_W-1:0] regf_addr_t;
  typedef logic [BIT_CNT_W-1:0]   bit_cnt_t;

  // index of the final bit in a word
  localparam bit_cnt_t LAST_BIT = bit_cnt_t'(WORD_BITS - 1);

  typedef enum logic [1:0] {
    IDLE     = 2'b00,
    CCC      = 2'b01,
    DDR_MODE = 2'b10
  } hdr_state_e;

  typedef enum logic {
    SRC_DDR = 1'b0,
    SRC_CCC = 1'b1
  } hdr_src_e;

  // only hdr-ddr allows a restart
  typedef enum logic [2:0] {
    MODE_HDR_DDR = 3'd6
  } hdr_mode_e;

  typedef struct packed {
    logic       tx_en;
    logic       rx_en;
    logic       regf_rd_en;
    regf_addr_t regf_addr;
    logic       scl_pp_od;   // 1 push-pull, 0 open drain
    logic       bit_cnt_en;
  } hdr_bus_ctrl_t;

  // all enables low, address parked
  function automatic hdr_bus_ctrl_t idle_ctrl(input int unsigned addr);
    hdr_bus_ctrl_t c;
    c           = '0;
    c.regf_addr = addr[REGF_ADDR_W-1:0];
    return c;
  endfunction

endpackage

//--- source/i3c_hdr_top.sv
// i3c hdr block top
`timescale 1ns/1ps

module i3c_hdr_top #(
  parameter int CCC_BASE_ADDR = 0,
  parameter int DDR_BASE_ADDR = 512,
  parameter int DUMMY_ADDR    = 450,
  parameter int IDLE_ADDR     = 1000
) (
  input  logic                       i_sys_clk,
  input  logic                       i_sys_rst_n,
  input  logic                       i_hdr_en,
  input  logic                       i_cp,
  input  logic                       i_toc,
  input  logic [2:0]                 i_mode,
  input  logic [3:0]                 i_frame_cnt,
  output logic                       o_hdr_done,
  output i3c_hdr_pkg::hdr_bus_ctrl_t o_bus_ctrl,
  output i3c_hdr_pkg::hdr_src_e      o_active_src
);

  logic                       ccc_en;
  logic                       ccc_dummy;
  logic                       ddr_en;
  logic                       ccc_done;
  logic                       ddr_done;
  i3c_hdr_pkg::hdr_bus_ctrl_t ccc_ctrl;
  i3c_hdr_pkg::hdr_bus_ctrl_t ddr_ctrl;

  hdr_engine #(
    .IDLE_ADDR (IDLE_ADDR)
  ) u_engine (
    .i_sys_clk    (i_sys_clk),
    .i_sys_rst_n  (i_sys_rst_n),
    .i_hdr_en     (i_hdr_en),
    .i_cp         (i_cp),
    .i_toc        (i_toc),
    .i_mode       (i_mode),
    .i_ccc_done   (ccc_done),
    .i_ddr_done   (ddr_done),
    .i_ccc_ctrl   (ccc_ctrl),
    .i_ddr_ctrl   (ddr_ctrl),
    .o_ccc_en     (ccc_en),
    .o_ccc_dummy  (ccc_dummy),
    .o_ddr_en     (ddr_en),
    .o_hdr_done   (o_hdr_done),
    .o_bus_ctrl   (o_bus_ctrl),
    .o_active_src (o_active_src)
  );

  hdr_ccc_unit #(
    .CCC_BASE_ADDR (CCC_BASE_ADDR),
    .DUMMY_ADDR    (DUMMY_ADDR),
    .IDLE_ADDR     (IDLE_ADDR)
  ) u_ccc (
    .i_sys_clk   (i_sys_clk),
    .i_sys_rst_n (i_sys_rst_n),
    .i_en        (ccc_en),
    .i_dummy     (ccc_dummy),
    .i_frame_cnt (i_frame_cnt),
    .o_done      (ccc_done),
    .o_ctrl      (ccc_ctrl)
  );

  hdr_ddr_unit #(
    .DDR_BASE_ADDR (DDR_BASE_ADDR),
    .IDLE_ADDR     (IDLE_ADDR)
  ) u_ddr (
    .i_sys_clk   (i_sys_clk),
    .i_sys_rst_n (i_sys_rst_n),
    .i_en        (ddr_en),
    .i_frame_cnt (i_frame_cnt),
    .o_done      (ddr_done),
    .o_ctrl      (ddr_ctrl)
  );

endmodule

//--- testbench/i3c_hdr_assert.sv
// hdr bus checker
`timescale 1ns/1ps

module i3c_hdr_assert #(
  parameter int CCC_BASE_ADDR = 0,
  parameter int DDR_BASE_ADDR = 512,
  parameter int DUMMY_ADDR    = 450,
  parameter int IDLE_ADDR     = 1000
) (
  input logic                       i_sys_clk,
  input logic                       i_sys_rst_n,
  input logic                       i_hdr_en,
  input logic                       i_hdr_done,
  input logic                       i_ccc_done,
  input logic                       i_ddr_done,
  input i3c_hdr_pkg::hdr_bus_ctrl_t i_bus_ctrl,
  input i3c_hdr_pkg::hdr_src_e      i_active_src
);

  int unsigned             fail_cnt = 0;
  logic                    src_ccc;
  logic                    bus_idle;
  logic                    at_dummy;
  i3c_hdr_pkg::regf_addr_t ccc_off;
  i3c_hdr_pkg::regf_addr_t ddr_off;

  assign src_ccc  = (i_active_src == i3c_hdr_pkg::SRC_CCC);
  assign at_dummy = (i_bus_ctrl.regf_addr == i3c_hdr_pkg::regf_addr_t'(DUMMY_ADDR));
  assign ccc_off  = i_bus_ctrl.regf_addr - i3c_hdr_pkg::regf_addr_t'(CCC_BASE_ADDR);
  assign ddr_off  = i_bus_ctrl.regf_addr - i3c_hdr_pkg::regf_addr_t'(DDR_BASE_ADDR);
  assign bus_idle = !i_bus_ctrl.tx_en && !i_bus_ctrl.rx_en && !i_bus_ctrl.regf_rd_en
                 && !i_bus_ctrl.bit_cnt_en
                 && (i_bus_ctrl.regf_addr == i3c_hdr_pkg::regf_addr_t'(IDLE_ADDR));

  // first cycle out of reset
  a_reset_state: assert property (@(posedge i_sys_clk)
    $rose(i_sys_rst_n) |-> (!i_hdr_done && bus_idle && src_ccc))
  else begin
    $error("outputs not at reset values after reset release");
    fail_cnt++;
  end

  a_done_single: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst_n)
    $past(i_hdr_done) |-> !i_hdr_done)
  else begin
    $error("o_hdr_done wider than one cycle");
    fail_cnt++;
  end

  // done only one cycle after a worker finished, and never after an abort
  a_done_cause: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst_n)
    i_hdr_done |-> ($past(i_ccc_done || i_ddr_done) && $past(i_hdr_en)))
  else begin
    $error("o_hdr_done without a finished worker");
    fail_cnt++;
  end

  a_ccc_reads: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst_n)
    (i_bus_ctrl.regf_rd_en && src_ccc) |-> ((ccc_off < 12'd15) || at_dummy))
  else begin
    $error("ccc read outside the ccc area");
    fail_cnt++;
  end

  a_ddr_reads: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst_n)
    (i_bus_ctrl.regf_rd_en && !src_ccc) |-> (ddr_off < 12'd15))
  else begin
    $error("ddr read outside the ddr area");
    fail_cnt++;
  end

  a_ddr_push_pull: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst_n)
    (i_bus_ctrl.bit_cnt_en && !src_ccc) |-> i_bus_ctrl.scl_pp_od)
  else begin
    $error("scl open drain during ddr");
    fail_cnt++;
  end

  // ccc to ddr without idling first must come out of the dummy word
  a_dummy_first: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst_n)
    ($fell(src_ccc) && i_bus_ctrl.bit_cnt_en) |-> at_dummy)
  else begin
    $error("switch to ddr without a dummy word");
    fail_cnt++;
  end

  a_abort_idle: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst_n)
    !$past(i_hdr_en, 2) |-> bus_idle)
  else begin
    $error("bus not idle two cycles after enable dropped");
    fail_cnt++;
  end

endmodule

bind i3c_hdr_top i3c_hdr_assert #(
  .CCC_BASE_ADDR (CCC_BASE_ADDR),
  .DDR_BASE_ADDR (DDR_BASE_ADDR),
  .DUMMY_ADDR    (DUMMY_ADDR),
  .IDLE_ADDR     (IDLE_ADDR)
) u_assert (
  .i_sys_clk    (i_sys_clk),
  .i_sys_rst_n  (i_sys_rst_n),
  .i_hdr_en     (i_hdr_en),
  .i_hdr_done   (o_hdr_done),
  .i_ccc_done   (ccc_done),
  .i_ddr_done   (ddr_done),
  .i_bus_ctrl   (o_bus_ctrl),
  .i_active_src (o_active_src)
);

//--- testbench/i3c_hdr_tb.sv
// i3c hdr testbench
`timescale 1ns/1ps

module i3c_hdr_tb;

  localparam int IDLE     = 1000;
  localparam int MAX_WAIT = 1500;  // ccc, dummy and ddr at 15 words each

  logic                       sys_clk;
  logic                       sys_rst_n;
  logic                       hdr_en;
  logic                       cp;
  logic                       toc;
  logic [2:0]                 mode;
  logic [3:0]                 frame_cnt;
  logic                       hdr_done;
  i3c_hdr_pkg::hdr_bus_ctrl_t bus_ctrl;
  i3c_hdr_pkg::hdr_src_e      active_src;
  integer                     seed = 10;
  int                         err_cnt = 0;
  int                         timeout_cnt = 0;
  int                         done_cnt = 0;
  int                         done_base = 0;

  i3c_hdr_top #(
    .CCC_BASE_ADDR (0),
    .DDR_BASE_ADDR (512),
    .DUMMY_ADDR    (450),
    .IDLE_ADDR     (IDLE)
  ) dut0 (
    .i_sys_clk    (sys_clk),
    .i_sys_rst_n  (sys_rst_n),
    .i_hdr_en     (hdr_en),
    .i_cp         (cp),
    .i_toc        (toc),
    .i_mode       (mode),
    .i_frame_cnt  (frame_cnt),
    .o_hdr_done   (hdr_done),
    .o_bus_ctrl   (bus_ctrl),
    .o_active_src (active_src)
  );

  initial begin
    sys_clk = 1'b0;
    forever #4 sys_clk = ~sys_clk;
  end

  // one cycle pulse, seen once per falling edge
  always @(negedge sys_clk) begin
    if (sys_rst_n && hdr_done) done_cnt++;
  end

  task automatic check_value(input string name, input int expected, input int actual);
    if (expected != actual) begin
      $display("[FAIL] %s expected %0d actual %0d", name, expected, actual);
      err_cnt++;
    end
  endtask

  task automatic wait_done(input string name);
    int n;
    n = 0;
    while (!hdr_done && n < MAX_WAIT) begin
      @(negedge sys_clk);
      n++;
    end
    if (!hdr_done) begin
      $display("%s: no done pulse within %0d cycles", name, MAX_WAIT);
      timeout_cnt++;
    end
  endtask

  task automatic start_transfer(input logic t_cp, input logic t_toc, input logic [2:0] t_mode);
    int r;
    r         = $random(seed);
    frame_cnt = 4'(($unsigned(r) % 15) + 1);
    cp        = t_cp;
    toc       = t_toc;
    mode      = t_mode;
    done_base = done_cnt;
    repeat (2) @(negedge sys_clk);  // idle latch picks up cp
    hdr_en = 1'b1;
  endtask

  task automatic end_transfer(input string name, input int exp_src);
    wait_done(name);
    check_value({name, " owner"}, exp_src, int'(active_src));
    hdr_en = 1'b0;
    repeat (3) @(negedge sys_clk);
    check_value({name, " done pulses"}, 1, done_cnt - done_base);
  endtask

  initial begin
    hdr_en    = 1'b0;
    cp        = 1'b0;
    toc       = 1'b1;
    mode      = 3'd6;
    frame_cnt = 4'd1;
    sys_rst_n = 1'b0;
    repeat (4) @(negedge sys_clk);
    check_value("reset done", 0, int'(hdr_done));
    check_value("reset enables", 0, int'({bus_ctrl.tx_en, bus_ctrl.rx_en,
                                          bus_ctrl.regf_rd_en, bus_ctrl.bit_cnt_en}));
    check_value("reset addr", IDLE, int'(bus_ctrl.regf_addr));
    check_value("reset owner", int'(i3c_hdr_pkg::SRC_CCC), int'(active_src));
    sys_rst_n = 1'b1;
    repeat (2) @(negedge sys_clk);

    start_transfer(1'b1, 1'b1, 3'd6);
    end_transfer("ccc_exit", int'(i3c_hdr_pkg::SRC_CCC));
    start_transfer(1'b0, 1'b1, 3'd6);
    end_transfer("ddr_exit", int'(i3c_hdr_pkg::SRC_DDR));

    // restart: ccc first, then ddr behind the dummy word
    start_transfer(1'b1, 1'b0, 3'd6);
    repeat (4) @(negedge sys_clk);
    cp  = 1'b0;
    toc = 1'b1;
    end_transfer("ccc_to_ddr", int'(i3c_hdr_pkg::SRC_DDR));

    start_transfer(1'b1, 1'b0, 3'd2);  // mode 2 forces exit
    end_transfer("mode_exit", int'(i3c_hdr_pkg::SRC_CCC));

    start_transfer(1'b0, 1'b1, 3'd6);
    repeat (10) @(negedge sys_clk);  // shorter than one word
    hdr_en = 1'b0;
    repeat (4) @(negedge sys_clk);
    check_value("abort tx_en", 0, int'(bus_ctrl.tx_en));
    // past the point where the aborted frame would have ended
    repeat (16 * i3c_hdr_pkg::WORD_BITS) @(negedge sys_clk);
    check_value("abort done pulses", 0, done_cnt - done_base);

    repeat (4) @(negedge sys_clk);
    $display("value errors %0d, assertion failures %0d, timeouts %0d",
             err_cnt, dut0.u_assert.fail_cnt, timeout_cnt);
    if (err_cnt == 0 && timeout_cnt == 0 && dut0.u_assert.fail_cnt == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule
